//--- Bender.yml
package:
  name: udp_rx

sources:
  - hw/stream_pkg.sv
  - hw/net_pkg.sv
  - hw/ip_frame_if.sv
  - hw/ip_protocol_demux.sv
  - hw/udp_header_parser.sv
  - hw/udp_rx_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_udp_rx.sv

//--- hw/ip_frame_if.sv
// IP frame interface: header fields, header handshake and payload stream, with modports
`timescale 1ns/1ps

interface ip_frame_if
    import stream_pkg::*, net_pkg::*;
();

    // Header
    logic     hdr_valid;
    logic     hdr_ready;
    dscp_t    dscp;
    ecn_t     ecn;
    len_t     length;
    ttl_t     ttl;
    ip_addr_t source_ip;
    ip_addr_t dest_ip;

    // Payload stream
    data_t    tdata;
    keep_t    tkeep;
    logic     tvalid;
    logic     tready;
    logic     tlast;
    logic     tuser;

    modport src (
        output hdr_valid, dscp, ecn, length, ttl, source_ip, dest_ip,
        output tdata, tkeep, tvalid, tlast, tuser,
        input  hdr_ready, tready
    );

    modport dst (
        input  hdr_valid, dscp, ecn, length, ttl, source_ip, dest_ip,
        input  tdata, tkeep, tvalid, tlast, tuser,
        output hdr_ready, tready
    );

endinterface

//--- hw/ip_protocol_demux.sv
// Protocol demux: steers each IP frame to the UDP stage or the IP output
`timescale 1ns/1ps

module ip_protocol_demux
    import stream_pkg::*, net_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      s_ip_hdr_valid,
    output logic      s_ip_hdr_ready,
    input  dscp_t     s_ip_dscp,
    input  ecn_t      s_ip_ecn,
    input  len_t      s_ip_length,
    input  ttl_t      s_ip_ttl,
    input  ip_proto_t s_ip_protocol,
    input  ip_addr_t  s_ip_source_ip,
    input  ip_addr_t  s_ip_dest_ip,
    input  data_t     s_ip_tdata,
    input  keep_t     s_ip_tkeep,
    input  logic      s_ip_tvalid,
    output logic      s_ip_tready,
    input  logic      s_ip_tlast,
    input  logic      s_ip_tuser,

    output logic      m_ip_hdr_valid,
    input  logic      m_ip_hdr_ready,
    output dscp_t     m_ip_dscp,
    output ecn_t      m_ip_ecn,
    output len_t      m_ip_length,
    output ttl_t      m_ip_ttl,
    output ip_proto_t m_ip_protocol,
    output ip_addr_t  m_ip_source_ip,
    output ip_addr_t  m_ip_dest_ip,
    output data_t     m_ip_tdata,
    output keep_t     m_ip_tkeep,
    output logic      m_ip_tvalid,
    input  logic      m_ip_tready,
    output logic      m_ip_tlast,
    output logic      m_ip_tuser,

    ip_frame_if.src   udp
);

    typedef enum logic [1:0] {
        ROUTE_NONE,
        ROUTE_IP,
        ROUTE_UDP
    } route_t;

    route_t route;
    logic   is_udp;
    logic   hdr_open;

    assign is_udp   = (s_ip_protocol == PROTO_UDP);
    // Next header waits until the previous payload has ended
    assign hdr_open = (route == ROUTE_NONE);

    // Header side, same cycle
    assign udp.hdr_valid  = s_ip_hdr_valid && hdr_open && is_udp;
    assign m_ip_hdr_valid = s_ip_hdr_valid && hdr_open && !is_udp;
    assign s_ip_hdr_ready = hdr_open && (is_udp ? udp.hdr_ready : m_ip_hdr_ready);

    assign udp.dscp      = s_ip_dscp;
    assign udp.ecn       = s_ip_ecn;
    assign udp.length    = s_ip_length;
    assign udp.ttl       = s_ip_ttl;
    assign udp.source_ip = s_ip_source_ip;
    assign udp.dest_ip   = s_ip_dest_ip;

    assign m_ip_dscp      = s_ip_dscp;
    assign m_ip_ecn       = s_ip_ecn;
    assign m_ip_length    = s_ip_length;
    assign m_ip_ttl       = s_ip_ttl;
    assign m_ip_protocol  = s_ip_protocol;
    assign m_ip_source_ip = s_ip_source_ip;
    assign m_ip_dest_ip   = s_ip_dest_ip;

    // Payload follows the stored route
    assign udp.tdata  = s_ip_tdata;
    assign udp.tkeep  = s_ip_tkeep;
    assign udp.tlast  = s_ip_tlast;
    assign udp.tuser  = s_ip_tuser;
    assign udp.tvalid = s_ip_tvalid && (route == ROUTE_UDP);

    assign m_ip_tdata  = s_ip_tdata;
    assign m_ip_tkeep  = s_ip_tkeep;
    assign m_ip_tlast  = s_ip_tlast;
    assign m_ip_tuser  = s_ip_tuser;
    assign m_ip_tvalid = s_ip_tvalid && (route == ROUTE_IP);

    assign s_ip_tready = ((route == ROUTE_UDP) && udp.tready) ||
                         ((route == ROUTE_IP) && m_ip_tready);

    always_ff @(posedge clk) begin
        if (rst) begin
            route <= ROUTE_NONE;
        end else if (s_ip_hdr_valid && s_ip_hdr_ready) begin
            route <= is_udp ? ROUTE_UDP : ROUTE_IP;
        end else if (s_ip_tvalid && s_ip_tready && s_ip_tlast) begin
            route <= ROUTE_NONE;
        end
    end

endmodule

//--- hw/net_pkg.sv
// IPv4 and UDP header field types and the UDP protocol number

package net_pkg;

    // IPv4 header fields that are carried past the parser
    typedef logic [31:0] ip_addr_t;
    typedef logic [5:0]  dscp_t;
    typedef logic [1:0]  ecn_t;
    typedef logic [7:0]  ttl_t;
    typedef logic [7:0]  ip_proto_t;

    // Total length in IP, datagram length in UDP
    typedef logic [15:0] len_t;

    // UDP header fields
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_csum_t;

    // IANA protocol number for UDP
    localparam ip_proto_t PROTO_UDP = 8'd17;

endpackage

//--- hw/stream_pkg.sv
// Payload stream word types: beat data and byte enables

package stream_pkg;

    // One payload beat of the 64-bit datapath
    typedef logic [63:0] data_t;

    // Byte enables, bit n qualifies tdata[8*n+7:8*n]
    typedef logic [7:0] keep_t;

endpackage

//--- hw/udp_header_parser.sv
// UDP header parser: takes the UDP header from the first beat, forwards the payload
`timescale 1ns/1ps

module udp_header_parser
    import stream_pkg::*, net_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    ip_frame_if.dst   ip,

    output logic      m_udp_hdr_valid,
    input  logic      m_udp_hdr_ready,
    output dscp_t     m_udp_ip_dscp,
    output ecn_t      m_udp_ip_ecn,
    output len_t      m_udp_ip_length,
    output ttl_t      m_udp_ip_ttl,
    output ip_addr_t  m_udp_ip_source_ip,
    output ip_addr_t  m_udp_ip_dest_ip,
    output udp_port_t m_udp_source_port,
    output udp_port_t m_udp_dest_port,
    output len_t      m_udp_length,
    output udp_csum_t m_udp_checksum,
    output data_t     m_udp_tdata,
    output keep_t     m_udp_tkeep,
    output logic      m_udp_tvalid,
    input  logic      m_udp_tready,
    output logic      m_udp_tlast,
    output logic      m_udp_tuser,

    output logic      busy,
    output logic      error_header_early_termination
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ_HEADER,
        ST_WAIT_HEADER_OUT,
        ST_PAYLOAD
    } parse_state_t;

    parse_state_t state;
    parse_state_t state_next;

    logic      hdr_accept;
    logic      first_beat;
    logic      payload_beat;
    logic      error_reg;

    dscp_t     ip_dscp_reg;
    ecn_t      ip_ecn_reg;
    len_t      ip_length_reg;
    ttl_t      ip_ttl_reg;
    ip_addr_t  ip_source_ip_reg;
    ip_addr_t  ip_dest_ip_reg;
    udp_port_t source_port_reg;
    udp_port_t dest_port_reg;
    len_t      udp_length_reg;
    udp_csum_t checksum_reg;

    assign hdr_accept   = (state == ST_IDLE) && ip.hdr_valid;
    assign first_beat   = (state == ST_READ_HEADER) && ip.tvalid;
    assign payload_beat = (state == ST_PAYLOAD) && ip.tvalid && m_udp_tready;

    assign ip.hdr_ready = (state == ST_IDLE);
    // Header beat is always taken, payload beats wait for the sink
    assign ip.tready    = (state == ST_READ_HEADER) ||
                          ((state == ST_PAYLOAD) && m_udp_tready);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (hdr_accept) begin
                    state_next = ST_READ_HEADER;
                end
            end
            ST_READ_HEADER: begin
                if (first_beat) begin
                    state_next = ip.tlast ? ST_IDLE : ST_WAIT_HEADER_OUT;
                end
            end
            ST_WAIT_HEADER_OUT: begin
                if (m_udp_hdr_ready) begin
                    state_next = ST_PAYLOAD;
                end
            end
            ST_PAYLOAD: begin
                if (payload_beat && ip.tlast) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            error_reg <= 1'b0;
        end else begin
            state     <= state_next;
            // Frame ended inside the UDP header
            error_reg <= first_beat && ip.tlast;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_accept) begin
            ip_dscp_reg      <= ip.dscp;
            ip_ecn_reg       <= ip.ecn;
            ip_length_reg    <= ip.length;
            ip_ttl_reg       <= ip.ttl;
            ip_source_ip_reg <= ip.source_ip;
            ip_dest_ip_reg   <= ip.dest_ip;
        end
        // Network byte order, byte 0 in tdata[7:0]
        if (first_beat) begin
            source_port_reg <= {ip.tdata[7:0], ip.tdata[15:8]};
            dest_port_reg   <= {ip.tdata[23:16], ip.tdata[31:24]};
            udp_length_reg  <= {ip.tdata[39:32], ip.tdata[47:40]};
            checksum_reg    <= {ip.tdata[55:48], ip.tdata[63:56]};
        end
    end

    assign m_udp_hdr_valid    = (state == ST_WAIT_HEADER_OUT);
    assign m_udp_ip_dscp      = ip_dscp_reg;
    assign m_udp_ip_ecn       = ip_ecn_reg;
    assign m_udp_ip_length    = ip_length_reg;
    assign m_udp_ip_ttl       = ip_ttl_reg;
    assign m_udp_ip_source_ip = ip_source_ip_reg;
    assign m_udp_ip_dest_ip   = ip_dest_ip_reg;
    assign m_udp_source_port  = source_port_reg;
    assign m_udp_dest_port    = dest_port_reg;
    assign m_udp_length       = udp_length_reg;
    assign m_udp_checksum     = checksum_reg;

    // Payload passes through with no added latency
    assign m_udp_tdata  = ip.tdata;
    assign m_udp_tkeep  = ip.tkeep;
    assign m_udp_tlast  = ip.tlast;
    assign m_udp_tuser  = ip.tuser;
    assign m_udp_tvalid = (state == ST_PAYLOAD) && ip.tvalid;

    assign busy                           = (state != ST_IDLE);
    assign error_header_early_termination = error_reg;

endmodule

//--- hw/udp_rx_top.sv
// UDP receive top level: protocol demux followed by the UDP header parser
`timescale 1ns/1ps

module udp_rx_top
    import stream_pkg::*, net_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // IP frame in
    input  logic      s_ip_hdr_valid,
    output logic      s_ip_hdr_ready,
    input  dscp_t     s_ip_dscp,
    input  ecn_t      s_ip_ecn,
    input  len_t      s_ip_length,
    input  ttl_t      s_ip_ttl,
    input  ip_proto_t s_ip_protocol,
    input  ip_addr_t  s_ip_source_ip,
    input  ip_addr_t  s_ip_dest_ip,
    input  data_t     s_ip_tdata,
    input  keep_t     s_ip_tkeep,
    input  logic      s_ip_tvalid,
    output logic      s_ip_tready,
    input  logic      s_ip_tlast,
    input  logic      s_ip_tuser,

    // Non-UDP frames out
    output logic      m_ip_hdr_valid,
    input  logic      m_ip_hdr_ready,
    output dscp_t     m_ip_dscp,
    output ecn_t      m_ip_ecn,
    output len_t      m_ip_length,
    output ttl_t      m_ip_ttl,
    output ip_proto_t m_ip_protocol,
    output ip_addr_t  m_ip_source_ip,
    output ip_addr_t  m_ip_dest_ip,
    output data_t     m_ip_tdata,
    output keep_t     m_ip_tkeep,
    output logic      m_ip_tvalid,
    input  logic      m_ip_tready,
    output logic      m_ip_tlast,
    output logic      m_ip_tuser,

    // UDP frames out
    output logic      m_udp_hdr_valid,
    input  logic      m_udp_hdr_ready,
    output dscp_t     m_udp_ip_dscp,
    output ecn_t      m_udp_ip_ecn,
    output len_t      m_udp_ip_length,
    output ttl_t      m_udp_ip_ttl,
    output ip_addr_t  m_udp_ip_source_ip,
    output ip_addr_t  m_udp_ip_dest_ip,
    output udp_port_t m_udp_source_port,
    output udp_port_t m_udp_dest_port,
    output len_t      m_udp_length,
    output udp_csum_t m_udp_checksum,
    output data_t     m_udp_tdata,
    output keep_t     m_udp_tkeep,
    output logic      m_udp_tvalid,
    input  logic      m_udp_tready,
    output logic      m_udp_tlast,
    output logic      m_udp_tuser,

    output logic      udp_rx_busy,
    output logic      udp_rx_error_header_early_termination
);

    ip_frame_if udp_if ();

    ip_protocol_demux demux_i (
        .clk            (clk),
        .rst            (rst),
        .s_ip_hdr_valid (s_ip_hdr_valid),
        .s_ip_hdr_ready (s_ip_hdr_ready),
        .s_ip_dscp      (s_ip_dscp),
        .s_ip_ecn       (s_ip_ecn),
        .s_ip_length    (s_ip_length),
        .s_ip_ttl       (s_ip_ttl),
        .s_ip_protocol  (s_ip_protocol),
        .s_ip_source_ip (s_ip_source_ip),
        .s_ip_dest_ip   (s_ip_dest_ip),
        .s_ip_tdata     (s_ip_tdata),
        .s_ip_tkeep     (s_ip_tkeep),
        .s_ip_tvalid    (s_ip_tvalid),
        .s_ip_tready    (s_ip_tready),
        .s_ip_tlast     (s_ip_tlast),
        .s_ip_tuser     (s_ip_tuser),
        .m_ip_hdr_valid (m_ip_hdr_valid),
        .m_ip_hdr_ready (m_ip_hdr_ready),
        .m_ip_dscp      (m_ip_dscp),
        .m_ip_ecn       (m_ip_ecn),
        .m_ip_length    (m_ip_length),
        .m_ip_ttl       (m_ip_ttl),
        .m_ip_protocol  (m_ip_protocol),
        .m_ip_source_ip (m_ip_source_ip),
        .m_ip_dest_ip   (m_ip_dest_ip),
        .m_ip_tdata     (m_ip_tdata),
        .m_ip_tkeep     (m_ip_tkeep),
        .m_ip_tvalid    (m_ip_tvalid),
        .m_ip_tready    (m_ip_tready),
        .m_ip_tlast     (m_ip_tlast),
        .m_ip_tuser     (m_ip_tuser),
        .udp            (udp_if.src)
    );

    udp_header_parser parser_i (
        .clk                            (clk),
        .rst                            (rst),
        .ip                             (udp_if.dst),
        .m_udp_hdr_valid                (m_udp_hdr_valid),
        .m_udp_hdr_ready                (m_udp_hdr_ready),
        .m_udp_ip_dscp                  (m_udp_ip_dscp),
        .m_udp_ip_ecn                   (m_udp_ip_ecn),
        .m_udp_ip_length                (m_udp_ip_length),
        .m_udp_ip_ttl                   (m_udp_ip_ttl),
        .m_udp_ip_source_ip             (m_udp_ip_source_ip),
        .m_udp_ip_dest_ip               (m_udp_ip_dest_ip),
        .m_udp_source_port              (m_udp_source_port),
        .m_udp_dest_port                (m_udp_dest_port),
        .m_udp_length                   (m_udp_length),
        .m_udp_checksum                 (m_udp_checksum),
        .m_udp_tdata                    (m_udp_tdata),
        .m_udp_tkeep                    (m_udp_tkeep),
        .m_udp_tvalid                   (m_udp_tvalid),
        .m_udp_tready                   (m_udp_tready),
        .m_udp_tlast                    (m_udp_tlast),
        .m_udp_tuser                    (m_udp_tuser),
        .busy                           (udp_rx_busy),
        .error_header_early_termination (udp_rx_error_header_early_termination)
    );

endmodule

//--- testbench/tb_udp_rx_tasks.svh
// Frame types, stimulus drive tasks, output collector and typed compare tasks
`ifndef TB_UDP_RX_TASKS_SVH
`define TB_UDP_RX_TASKS_SVH

typedef struct packed {
    dscp_t     dscp;
    ecn_t      ecn;
    len_t      length;
    ttl_t      ttl;
    ip_proto_t protocol;
    ip_addr_t  source_ip;
    ip_addr_t  dest_ip;
} ip_hdr_t;

typedef struct packed {
    ip_hdr_t   ip;
    udp_port_t source_port;
    udp_port_t dest_port;
    len_t      length;
    udp_csum_t checksum;
} udp_hdr_t;

typedef struct packed {
    data_t tdata;
    keep_t tkeep;
    logic  tlast;
    logic  tuser;
} beat_t;

ip_hdr_t  exp_ip_hdr[$];
ip_hdr_t  got_ip_hdr[$];
udp_hdr_t exp_udp_hdr[$];
udp_hdr_t got_udp_hdr[$];
beat_t    exp_ip_beat[$];
beat_t    got_ip_beat[$];
beat_t    exp_udp_beat[$];
beat_t    got_udp_beat[$];
beat_t    frame_q[$];
int       exp_errors = 0;
int       got_errors = 0;

function automatic beat_t random_beat(logic last);
    beat_t b;
    b.tdata = {$random(seed), $random(seed)};
    // Partial byte enables only on the closing beat
    b.tkeep = last ? (keep_t'($random(seed)) | 8'h01) : 8'hff;
    b.tlast = last;
    b.tuser = last ? 1'($random(seed)) : 1'b0;
    return b;
endfunction

function automatic ip_hdr_t random_ip_hdr(ip_proto_t proto);
    ip_hdr_t h;
    h.dscp      = dscp_t'($random(seed));
    h.ecn       = ecn_t'($random(seed));
    h.length    = len_t'($random(seed));
    h.ttl       = ttl_t'($random(seed));
    h.protocol  = proto;
    h.source_ip = $random(seed);
    h.dest_ip   = $random(seed);
    return h;
endfunction

task automatic stop_with_failure(string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "Run stopped at the first error");
endtask

task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
    stop_with_failure($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
endtask

// Header first, then every beat of frame_q
task automatic drive_frame(ip_hdr_t hdr);
    s_ip_hdr_valid <= 1'b1;
    s_ip_dscp      <= hdr.dscp;
    s_ip_ecn       <= hdr.ecn;
    s_ip_length    <= hdr.length;
    s_ip_ttl       <= hdr.ttl;
    s_ip_protocol  <= hdr.protocol;
    s_ip_source_ip <= hdr.source_ip;
    s_ip_dest_ip   <= hdr.dest_ip;
    do @(posedge clk); while (!s_ip_hdr_ready);
    s_ip_hdr_valid <= 1'b0;
    foreach (frame_q[i]) begin
        s_ip_tvalid <= 1'b1;
        s_ip_tdata  <= frame_q[i].tdata;
        s_ip_tkeep  <= frame_q[i].tkeep;
        s_ip_tlast  <= frame_q[i].tlast;
        s_ip_tuser  <= frame_q[i].tuser;
        do @(posedge clk); while (!s_ip_tready);
    end
    s_ip_tvalid <= 1'b0;
    frame_q.delete();
endtask

// UDP frame with the header beat plus payload_beats further beats
task automatic send_udp(int payload_beats);
    ip_hdr_t  hdr;
    udp_hdr_t uh;
    beat_t    b;
    hdr            = random_ip_hdr(PROTO_UDP);
    uh.ip          = hdr;
    uh.source_port = udp_port_t'($random(seed));
    uh.dest_port   = udp_port_t'($random(seed));
    uh.length      = len_t'($random(seed));
    uh.checksum    = udp_csum_t'($random(seed));
    // Big-endian fields with the first wire byte in bits 7:0
    b.tdata = {uh.checksum[7:0], uh.checksum[15:8], uh.length[7:0], uh.length[15:8],
               uh.dest_port[7:0], uh.dest_port[15:8],
               uh.source_port[7:0], uh.source_port[15:8]};
    b.tkeep = 8'hff;
    b.tlast = (payload_beats == 0);
    b.tuser = 1'b0;
    frame_q.push_back(b);
    if (payload_beats == 0) begin
        exp_errors++;
    end else begin
        exp_udp_hdr.push_back(uh);
    end
    for (int i = 0; i < payload_beats; i++) begin
        b = random_beat(i == payload_beats - 1);
        frame_q.push_back(b);
        exp_udp_beat.push_back(b);
    end
    drive_frame(hdr);
endtask

task automatic send_ip(ip_proto_t proto, int beats);
    ip_hdr_t hdr;
    beat_t   b;
    hdr = random_ip_hdr(proto);
    exp_ip_hdr.push_back(hdr);
    for (int i = 0; i < beats; i++) begin
        b = random_beat(i == beats - 1);
        frame_q.push_back(b);
        exp_ip_beat.push_back(b);
    end
    drive_frame(hdr);
endtask

task automatic collect_outputs();
    ip_hdr_t  h;
    udp_hdr_t uh;
    if (m_ip_hdr_valid && m_ip_hdr_ready) begin
        h = {m_ip_dscp, m_ip_ecn, m_ip_length, m_ip_ttl, m_ip_protocol,
             m_ip_source_ip, m_ip_dest_ip};
        got_ip_hdr.push_back(h);
    end
    if (m_ip_tvalid && m_ip_tready) begin
        got_ip_beat.push_back({m_ip_tdata, m_ip_tkeep, m_ip_tlast, m_ip_tuser});
    end
    if (m_udp_hdr_valid && m_udp_hdr_ready) begin
        uh.ip = {m_udp_ip_dscp, m_udp_ip_ecn, m_udp_ip_length, m_udp_ip_ttl, PROTO_UDP,
                 m_udp_ip_source_ip, m_udp_ip_dest_ip};
        uh.source_port = m_udp_source_port;
        uh.dest_port   = m_udp_dest_port;
        uh.length      = m_udp_length;
        uh.checksum    = m_udp_checksum;
        got_udp_hdr.push_back(uh);
    end
    if (m_udp_tvalid && m_udp_tready) begin
        got_udp_beat.push_back({m_udp_tdata, m_udp_tkeep, m_udp_tlast, m_udp_tuser});
    end
    if (udp_rx_error_header_early_termination) begin
        got_errors++;
    end
endtask

// IP fields that both output ports carry
task automatic check_ip_fields(string port, ip_hdr_t got, ip_hdr_t exp);
    if (got.dscp !== exp.dscp) report_mismatch({port, "_dscp"}, got.dscp, exp.dscp);
    if (got.ecn !== exp.ecn) report_mismatch({port, "_ecn"}, got.ecn, exp.ecn);
    if (got.length !== exp.length) report_mismatch({port, "_length"}, got.length, exp.length);
    if (got.ttl !== exp.ttl) report_mismatch({port, "_ttl"}, got.ttl, exp.ttl);
    if (got.source_ip !== exp.source_ip) begin
        report_mismatch({port, "_source_ip"}, got.source_ip, exp.source_ip);
    end
    if (got.dest_ip !== exp.dest_ip) begin
        report_mismatch({port, "_dest_ip"}, got.dest_ip, exp.dest_ip);
    end
endtask

task automatic check_ip_header(string port, ip_hdr_t got, ip_hdr_t exp);
    check_ip_fields(port, got, exp);
    if (got.protocol !== exp.protocol) begin
        report_mismatch({port, "_protocol"}, got.protocol, exp.protocol);
    end
endtask

task automatic check_udp_header(udp_hdr_t got, udp_hdr_t exp);
    // The m_udp port carries no protocol field
    check_ip_fields("m_udp_ip", got.ip, exp.ip);
    if (got.source_port !== exp.source_port) begin
        report_mismatch("m_udp_source_port", got.source_port, exp.source_port);
    end
    if (got.dest_port !== exp.dest_port) begin
        report_mismatch("m_udp_dest_port", got.dest_port, exp.dest_port);
    end
    if (got.length !== exp.length) report_mismatch("m_udp_length", got.length, exp.length);
    if (got.checksum !== exp.checksum) begin
        report_mismatch("m_udp_checksum", got.checksum, exp.checksum);
    end
endtask

task automatic check_beat(string port, beat_t got, beat_t exp);
    if (got.tdata !== exp.tdata) report_mismatch({port, "_tdata"}, got.tdata, exp.tdata);
    if (got.tkeep !== exp.tkeep) report_mismatch({port, "_tkeep"}, got.tkeep, exp.tkeep);
    if (got.tlast !== exp.tlast) report_mismatch({port, "_tlast"}, got.tlast, exp.tlast);
    if (got.tuser !== exp.tuser) report_mismatch({port, "_tuser"}, got.tuser, exp.tuser);
endtask

task automatic check_error(int got, int exp);
    if (got != exp) report_mismatch("udp_rx_error_header_early_termination pulses", got, exp);
endtask

// Waits for every expected transfer and then compares in order
task automatic verify_outputs();
    while (got_ip_hdr.size() < exp_ip_hdr.size() || got_ip_beat.size() < exp_ip_beat.size() ||
           got_udp_hdr.size() < exp_udp_hdr.size() ||
           got_udp_beat.size() < exp_udp_beat.size() || got_errors < exp_errors) begin
        @(posedge clk);
    end
    repeat (2) @(posedge clk);
    if (got_ip_hdr.size() > exp_ip_hdr.size()) stop_with_failure("Unexpected header on m_ip");
    if (got_ip_beat.size() > exp_ip_beat.size()) stop_with_failure("Unexpected beat on m_ip");
    if (got_udp_hdr.size() > exp_udp_hdr.size()) stop_with_failure("Unexpected header on m_udp");
    if (got_udp_beat.size() > exp_udp_beat.size()) stop_with_failure("Unexpected beat on m_udp");
    while (exp_ip_hdr.size() > 0) begin
        check_ip_header("m_ip", got_ip_hdr.pop_front(), exp_ip_hdr.pop_front());
    end
    while (exp_ip_beat.size() > 0) begin
        check_beat("m_ip", got_ip_beat.pop_front(), exp_ip_beat.pop_front());
    end
    while (exp_udp_hdr.size() > 0) begin
        check_udp_header(got_udp_hdr.pop_front(), exp_udp_hdr.pop_front());
    end
    while (exp_udp_beat.size() > 0) begin
        check_beat("m_udp", got_udp_beat.pop_front(), exp_udp_beat.pop_front());
    end
    check_error(got_errors, exp_errors);
endtask

`endif

//--- testbench/tb_udp_rx.sv
// Testbench top for udp_rx_top: clock, reset, DUT, sink readies, timeout and directed tests
`timescale 1ns/1ps

module tb_udp_rx
    import stream_pkg::*, net_pkg::*;
();

    // 3 + 3 + 3 + 12 + 9 beats over the five tests
    localparam int TOTAL_BEATS = 30;
    localparam int CYCLE_LIMIT = TOTAL_BEATS * 20 + 200;

    logic      clk;
    logic      rst;
    logic      s_ip_hdr_valid, s_ip_hdr_ready, s_ip_tvalid, s_ip_tready;
    logic      s_ip_tlast, s_ip_tuser;
    dscp_t     s_ip_dscp, m_ip_dscp, m_udp_ip_dscp;
    ecn_t      s_ip_ecn, m_ip_ecn, m_udp_ip_ecn;
    len_t      s_ip_length, m_ip_length, m_udp_ip_length, m_udp_length;
    ttl_t      s_ip_ttl, m_ip_ttl, m_udp_ip_ttl;
    ip_proto_t s_ip_protocol, m_ip_protocol;
    ip_addr_t  s_ip_source_ip, s_ip_dest_ip, m_ip_source_ip, m_ip_dest_ip;
    ip_addr_t  m_udp_ip_source_ip, m_udp_ip_dest_ip;
    data_t     s_ip_tdata, m_ip_tdata, m_udp_tdata;
    keep_t     s_ip_tkeep, m_ip_tkeep, m_udp_tkeep;
    logic      m_ip_hdr_valid, m_ip_hdr_ready, m_ip_tvalid, m_ip_tready;
    logic      m_ip_tlast, m_ip_tuser;
    logic      m_udp_hdr_valid, m_udp_hdr_ready, m_udp_tvalid, m_udp_tready;
    logic      m_udp_tlast, m_udp_tuser;
    udp_port_t m_udp_source_port, m_udp_dest_port;
    udp_csum_t m_udp_checksum;
    logic      udp_rx_busy, udp_rx_error_header_early_termination;

    integer seed = 87;
    logic   random_ready = 1'b0;
    int     cycles = 0;

    `include "tb_udp_rx_tasks.svh"

    udp_rx_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Sinks stall at random during the back-pressure test
    always @(posedge clk) begin
        if (random_ready) begin
            m_udp_hdr_ready <= 1'($random(seed));
            m_udp_tready    <= 1'($random(seed));
            m_ip_tready     <= 1'($random(seed));
        end else begin
            m_udp_hdr_ready <= 1'b1;
            m_udp_tready    <= 1'b1;
            m_ip_tready     <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            collect_outputs();
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            stop_with_failure($sformatf("Timeout after %0d cycles, transfers missing", cycles));
        end
    end

    task automatic test_udp_frame();
        send_udp(2);
        verify_outputs();
    endtask

    task automatic test_tcp_frame();
        send_ip(8'd6, 3);
        verify_outputs();
    endtask

    task automatic test_early_termination();
        send_udp(0);
        send_udp(1);
        verify_outputs();
    endtask

    task automatic test_back_pressure();
        random_ready <= 1'b1;
        send_udp(3);
        send_ip(8'd6, 4);
        send_udp(3);
        verify_outputs();
        random_ready <= 1'b0;
        @(posedge clk);
    endtask

    task automatic test_mixed_frames();
        send_udp(1);
        send_ip(8'd1, 3);
        send_udp(2);
        send_ip(8'd6, 1);
        @(posedge clk);
        if (udp_rx_busy !== 1'b0) report_mismatch("udp_rx_busy", udp_rx_busy, 1'b0);
        verify_outputs();
    endtask

    initial begin
        rst             = 1'b1;
        s_ip_hdr_valid  = 1'b0;
        s_ip_dscp       = '0;
        s_ip_ecn        = '0;
        s_ip_length     = '0;
        s_ip_ttl        = '0;
        s_ip_protocol   = '0;
        s_ip_source_ip  = '0;
        s_ip_dest_ip    = '0;
        s_ip_tdata      = '0;
        s_ip_tkeep      = '0;
        s_ip_tvalid     = 1'b0;
        s_ip_tlast      = 1'b0;
        s_ip_tuser      = 1'b0;
        m_ip_hdr_ready  = 1'b1;
        m_ip_tready     = 1'b1;
        m_udp_hdr_ready = 1'b1;
        m_udp_tready    = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_udp_frame();
        test_tcp_frame();
        test_early_termination();
        test_back_pressure();
        test_mixed_frames();
        $display("** PASS **");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+testbench
hw/stream_pkg.sv
hw/net_pkg.sv
hw/ip_frame_if.sv
hw/ip_protocol_demux.sv
hw/udp_header_parser.sv
hw/udp_rx_top.sv
testbench/tb_udp_rx.sv
